// File: verification/ncpu_msr_cases.txt
# op reg data data2 expected, all hex, one clock cycle per line
# W writes data to reg (6..F take random data), R checks rd_data and for reg 3 also epc
# E enters with exc_pc=data, exc_lsa=data2, a reg below F also gets data2 written that cycle
# W, E, X and P check psr in their own cycle
R 0 0 0 010
R 1 0 0 030C0001
R 2 0 0 0
R 3 0 0 0
R 4 0 0 0
R 5 0 0 3
W 0 FFFFFFFF 0 0F0
W 2 FFFFFF6F 0 0F0
R 2 0 0 060
W 3 80001234 0 0F0
R 3 0 0 80001234
W 4 00C0FFEE 0 0F0
W 1 FFFFFFFF 0 0F0
W 5 12345678 0 0F0
W A 0 0 0F0
R 4 0 0 00C0FFEE
R 1 0 0 030C0001
R 5 0 0 3
E F 00001000 00002000 010
R 2 0 0 0F0
R 3 0 0 00001000
R 4 0 0 00002000
X 0 0 0 0F0
W 2 00000020 0 0F0
X 0 0 0 020
W 0 00000040 0 040
E 0 00003000 000000A0 010
R 2 0 0 0A0
E 3 00004000 00000FFF 010
R 3 0 0 00004000
R 2 0 0 010
P 0 0 0 010

// File: ncpu_msr.f
+incdir+rtl
rtl/ncpu_msr_pkg.sv
rtl/ncpu_psr.sv
rtl/ncpu_exc_regs.sv
rtl/ncpu_msr_access.sv
rtl/ncpu_msr.sv
verification/ncpu_msr_tb.sv

// File: Makefile
SIM        = verilator
TOP        = ncpu_msr_tb
FILELIST   = ncpu_msr.f
OBJ_DIR    = obj_dir
FLAGS      = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: verification/ncpu_msr_tb.sv
// Case-file driven testbench for the machine-state register unit, run from the project root
`timescale 1ns/1ps
`default_nettype none
`include "ncpu_msr_defs.svh"

module ncpu_msr_tb;

   localparam int RST_CYCLES  = 16;
   localparam int RST_TIMEOUT = 64;
   localparam int LINE_LIMIT  = 1000;

   logic                    clk;
   logic                    rst_n;
   logic                    exc_ent;
   logic [`NCPU_DW-1:0]     exc_pc;
   logic [`NCPU_DW-1:0]     exc_lsa;
   logic                    exc_ret;
   logic                    wr_en;
   ncpu_msr_pkg::msr_addr_t wr_addr;
   logic [`NCPU_DW-1:0]     wr_data;
   ncpu_msr_pkg::msr_addr_t rd_addr;
   logic [`NCPU_DW-1:0]     rd_data;
   ncpu_msr_pkg::psr_t      psr;
   logic [`NCPU_DW-1:0]     epc;

   ncpu_msr #(
      .CORE_ID (32'd3)
   ) ncpu_msr_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .exc_ent (exc_ent),
      .exc_pc  (exc_pc),
      .exc_lsa (exc_lsa),
      .exc_ret (exc_ret),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data),
      .psr     (psr),
      .epc     (epc)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_psr(input string name, input ncpu_msr_pkg::psr_t exp,
                            input ncpu_msr_pkg::psr_t act);
      if (act !== exp) begin
         fail_run($sformatf("Fail at time %0t: %s expected %h, got %h", $time, name, exp, act));
      end
   endtask

   task automatic check_word(input string name, input logic [`NCPU_DW-1:0] exp,
                             input logic [`NCPU_DW-1:0] act);
      if (act !== exp) begin
         fail_run($sformatf("Fail at time %0t: %s expected %h, got %h", $time, name, exp, act));
      end
   endtask

   // One case line takes one clock cycle
   task automatic run_case(input logic [7:0] op, input logic [3:0] num,
                           input logic [`NCPU_DW-1:0] d1, input logic [`NCPU_DW-1:0] d2,
                           input logic [`NCPU_DW-1:0] exp_val);
      @(posedge clk);
      #1;
      exc_ent = 1'b0;
      exc_ret = 1'b0;
      wr_en   = 1'b0;
      exc_lsa = $urandom;
      case (op)
         "W": begin
            wr_en   = 1'b1;
            wr_addr = ncpu_msr_pkg::msr_addr_t'(num);
            // Unknown numbers get filler data
            wr_data = (num > 4'd5) ? $urandom : d1;
         end
         "R": rd_addr = ncpu_msr_pkg::msr_addr_t'(num);
         "E": begin
            exc_ent = 1'b1;
            exc_pc  = d1;
            exc_lsa = d2;
            if (num != 4'hf) begin
               wr_en   = 1'b1;
               wr_addr = ncpu_msr_pkg::msr_addr_t'(num);
               wr_data = d2;
            end
         end
         "X": exc_ret = 1'b1;
         "P": ;
         default: fail_run($sformatf("Unknown opcode %c in the case file", op));
      endcase
      // Sample well before the next edge
      #2;
      if (op == "R") begin
         check_word("rd_data", exp_val, rd_data);
         if (num == 4'd3) begin
            check_word("epc", exp_val, epc);
         end
      end else begin
         check_psr("psr", ncpu_msr_pkg::psr_t'(exp_val[`NCPU_PSR_DW-1:0]), psr);
      end
   endtask

   initial begin
      int                  fd;
      int                  cnt;
      int                  lines;
      int                  waited;
      string               line;
      logic [7:0]          op;
      logic [3:0]          num;
      logic [`NCPU_DW-1:0] d1;
      logic [`NCPU_DW-1:0] d2;
      logic [`NCPU_DW-1:0] exp_val;

      void'($urandom(22174));
      exc_ent = 1'b0;
      exc_pc  = '0;
      exc_lsa = '0;
      exc_ret = 1'b0;
      wr_en   = 1'b0;
      wr_addr = ncpu_msr_pkg::MSR_PSR;
      wr_data = '0;
      rd_addr = ncpu_msr_pkg::MSR_PSR;

      waited = 0;
      while (rst_n !== 1'b1) begin
         if (waited == RST_TIMEOUT) begin
            fail_run("Reset was never released");
         end
         @(posedge clk);
         waited++;
      end

      fd = $fopen("verification/ncpu_msr_cases.txt", "r");
      if (fd == 0) begin
         fail_run("Cannot open the case file");
      end
      lines = 0;
      while (!$feof(fd)) begin
         if (lines == LINE_LIMIT) begin
            fail_run("Case file did not end within the line limit");
         end
         lines++;
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line[0] == "#") begin
            continue;
         end
         cnt = $sscanf(line, "%c %h %h %h %h", op, num, d1, d2, exp_val);
         if (cnt != 5) begin
            fail_run($sformatf("Malformed case line %0d", lines));
         end
         run_case(op, num, d1, d2, exp_val);
      end
      $fclose(fd);

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: rtl/ncpu_msr.sv
// Machine-state register unit top, joining the PSR, exception registers and access path
`timescale 1ns/1ps
`default_nettype none
`include "ncpu_msr_defs.svh"

module ncpu_msr #(
   parameter logic [`NCPU_DW-1:0] CORE_ID = '0
) (
   input  wire logic                    clk,
   input  wire logic                    rst_n,
   input  wire logic                    exc_ent,
   input  wire logic [`NCPU_DW-1:0]     exc_pc,
   input  wire logic [`NCPU_DW-1:0]     exc_lsa,
   input  wire logic                    exc_ret,
   input  wire logic                    wr_en,
   input  wire ncpu_msr_pkg::msr_addr_t wr_addr,
   input  wire logic [`NCPU_DW-1:0]     wr_data,
   input  wire ncpu_msr_pkg::msr_addr_t rd_addr,
   output logic [`NCPU_DW-1:0]          rd_data,
   output ncpu_msr_pkg::psr_t           psr,
   output logic [`NCPU_DW-1:0]          epc
);

   logic                psr_we;
   logic                epsr_we;
   logic                epc_we;
   logic                elsa_we;
   ncpu_msr_pkg::psr_t  psr_wdata;
   ncpu_msr_pkg::psr_t  psr_nold;
   ncpu_msr_pkg::psr_t  epsr;
   logic [`NCPU_DW-1:0] elsa;

   ncpu_psr psr_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .exc_ent   (exc_ent),
      .exc_ret   (exc_ret),
      .psr_we    (psr_we),
      .psr_wdata (psr_wdata),
      .epsr      (epsr),
      .psr       (psr),
      .psr_nold  (psr_nold)
   );

   ncpu_exc_regs exc_regs_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .exc_ent  (exc_ent),
      .epsr_we  (epsr_we),
      .epc_we   (epc_we),
      .elsa_we  (elsa_we),
      .psr_nold (psr_nold),
      .exc_pc   (exc_pc),
      .exc_lsa  (exc_lsa),
      .wr_data  (wr_data),
      .epsr     (epsr),
      .epc      (epc),
      .elsa     (elsa)
   );

   ncpu_msr_access #(
      .CORE_ID (CORE_ID)
   ) access_inst (
      .wr_en     (wr_en),
      .wr_addr   (wr_addr),
      .rd_addr   (rd_addr),
      .wr_data   (wr_data),
      .psr       (psr),
      .epsr      (epsr),
      .epc       (epc),
      .elsa      (elsa),
      .psr_we    (psr_we),
      .epsr_we   (epsr_we),
      .epc_we    (epc_we),
      .elsa_we   (elsa_we),
      .psr_wdata (psr_wdata),
      .rd_data   (rd_data)
   );

endmodule

`default_nettype wire

// File: rtl/ncpu_msr_access.sv
// Software access path: write decode by register number and combinational read multiplexer
`timescale 1ns/1ps
`default_nettype none
`include "ncpu_msr_defs.svh"

module ncpu_msr_access #(
   parameter logic [`NCPU_DW-1:0] CORE_ID = '0
) (
   input  wire logic                    wr_en,
   input  wire ncpu_msr_pkg::msr_addr_t wr_addr,
   input  wire ncpu_msr_pkg::msr_addr_t rd_addr,
   input  wire logic [`NCPU_DW-1:0]     wr_data,
   input  wire ncpu_msr_pkg::psr_t      psr,
   input  wire ncpu_msr_pkg::psr_t      epsr,
   input  wire logic [`NCPU_DW-1:0]     epc,
   input  wire logic [`NCPU_DW-1:0]     elsa,
   output logic                         psr_we,
   output logic                         epsr_we,
   output logic                         epc_we,
   output logic                         elsa_we,
   output ncpu_msr_pkg::psr_t           psr_wdata,
   output logic [`NCPU_DW-1:0]          rd_data
);

   // Only the four defined bits reach the PSR
   assign psr_wdata = ncpu_msr_pkg::psr_t'(wr_data[`NCPU_PSR_DW-1:0] & `NCPU_PSR_MASK);

   // CPUID, COREID and unknown numbers are read only
   always_comb begin
      psr_we  = 1'b0;
      epsr_we = 1'b0;
      epc_we  = 1'b0;
      elsa_we = 1'b0;
      if (wr_en) begin
         case (wr_addr)
            ncpu_msr_pkg::MSR_PSR:  psr_we  = 1'b1;
            ncpu_msr_pkg::MSR_EPSR: epsr_we = 1'b1;
            ncpu_msr_pkg::MSR_EPC:  epc_we  = 1'b1;
            ncpu_msr_pkg::MSR_ELSA: elsa_we = 1'b1;
            default: ;
         endcase
      end
   end

   always_comb begin
      case (rd_addr)
         ncpu_msr_pkg::MSR_PSR:    rd_data = {{(`NCPU_DW-`NCPU_PSR_DW){1'b0}}, psr};
         ncpu_msr_pkg::MSR_CPUID:  rd_data = `NCPU_CPUID_VAL;
         ncpu_msr_pkg::MSR_EPSR:   rd_data = {{(`NCPU_DW-`NCPU_PSR_DW){1'b0}}, epsr};
         ncpu_msr_pkg::MSR_EPC:    rd_data = epc;
         ncpu_msr_pkg::MSR_ELSA:   rd_data = elsa;
         ncpu_msr_pkg::MSR_COREID: rd_data = CORE_ID;
         default:                  rd_data = '0;
      endcase
   end

   // One register per write
   always_comb begin
      a_we_onehot: assert ($onehot0({psr_we, epsr_we, epc_we, elsa_we}))
         else $error("More than one MSR write enable");
   end

endmodule

`default_nettype wire

// File: rtl/ncpu_exc_regs.sv
// EPSR, EPC and ELSA registers, loaded by exception entry or by software writes
`timescale 1ns/1ps
`default_nettype none
`include "ncpu_msr_defs.svh"

module ncpu_exc_regs (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire logic                exc_ent,
   input  wire logic                epsr_we,
   input  wire logic                epc_we,
   input  wire logic                elsa_we,
   input  wire ncpu_msr_pkg::psr_t  psr_nold,
   input  wire logic [`NCPU_DW-1:0] exc_pc,
   input  wire logic [`NCPU_DW-1:0] exc_lsa,
   input  wire logic [`NCPU_DW-1:0] wr_data,
   output ncpu_msr_pkg::psr_t       epsr,
   output logic [`NCPU_DW-1:0]      epc,
   output logic [`NCPU_DW-1:0]      elsa
);

   logic [`NCPU_PSR_DW-1:0] epsr_nxt;

   // Saved PSR keeps only the defined bits
   assign epsr_nxt = exc_ent ? (psr_nold & `NCPU_PSR_MASK)
                             : (wr_data[`NCPU_PSR_DW-1:0] & `NCPU_PSR_MASK);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         epsr <= '0;
      end else if (exc_ent || epsr_we) begin
         epsr <= ncpu_msr_pkg::psr_t'(epsr_nxt);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         epc <= '0;
      end else if (exc_ent) begin
         epc <= exc_pc;
      end else if (epc_we) begin
         epc <= wr_data;
      end
   end

   // Faulting load/store address
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         elsa <= '0;
      end else if (exc_ent) begin
         elsa <= exc_lsa;
      end else if (elsa_we) begin
         elsa <= wr_data;
      end
   end

   // A same-cycle EPC write must lose to the entry
   a_ent_wins_epc: assert property (
      @(posedge clk) disable iff (!rst_n)
      exc_ent |=> (epc == $past(exc_pc))
   ) else $error("EPC does not hold exc_pc after entry");

endmodule

`default_nettype wire

// File: rtl/ncpu_psr.sv
// PSR bit registers with exception entry forcing, return restore and same-cycle bypass
`timescale 1ns/1ps
`default_nettype none

module ncpu_psr (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire logic               exc_ent,
   input  wire logic               exc_ret,
   input  wire logic               psr_we,
   input  wire ncpu_msr_pkg::psr_t psr_wdata,
   input  wire ncpu_msr_pkg::psr_t epsr,
   output ncpu_msr_pkg::psr_t      psr,
   output ncpu_msr_pkg::psr_t      psr_nold
);

   // Bit order {dmme, imme, ire, rm}
   logic [3:0] bits_r;
   logic [3:0] bits_nxt;
   logic [3:0] bits_wr;
   logic [3:0] bits_ep;
   logic [3:0] bits_cur;
   logic [3:0] bits_nold;
   logic       bits_ld;

   function automatic ncpu_msr_pkg::psr_t pack_psr(input logic [3:0] b);
      ncpu_msr_pkg::psr_t p;
      p      = '0;
      p.dmme = b[3];
      p.imme = b[2];
      p.ire  = b[1];
      p.rm   = b[0];
      return p;
   endfunction

   assign bits_wr = {psr_wdata.dmme, psr_wdata.imme, psr_wdata.ire, psr_wdata.rm};
   assign bits_ep = {epsr.dmme, epsr.imme, epsr.ire, epsr.rm};
   assign bits_ld = exc_ent | exc_ret | psr_we;

   // Entry beats return, return beats software write
   always_comb begin
      if (exc_ent) begin
         bits_nxt = 4'b0001;
      end else if (exc_ret) begin
         bits_nxt = bits_ep;
      end else begin
         bits_nxt = bits_wr;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bits_r <= 4'b0001;
      end else if (bits_ld) begin
         bits_r <= bits_nxt;
      end
   end

   // Current view shows the pending update in its own cycle
   assign bits_cur = bits_ld ? bits_nxt : bits_r;

   // Software write only, what entry saves to EPSR
   assign bits_nold = psr_we ? bits_wr : bits_r;

   assign psr      = pack_psr(bits_cur);
   assign psr_nold = pack_psr(bits_nold);

   a_ent_ret_excl: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(exc_ent && exc_ret)
   ) else $error("exc_ent and exc_ret high together");

   a_ent_forces: assert property (
      @(posedge clk) disable iff (!rst_n)
      exc_ent |=> (bits_r[0] && !bits_r[1])
   ) else $error("PSR not privileged with interrupts off after entry");

endmodule

`default_nettype wire

// File: rtl/ncpu_msr_pkg.sv
// Shared PSR layout and register numbers, referenced by scoped name from the RTL and testbench
`default_nettype none

package ncpu_msr_pkg;

   // PSR layout, MSB first, reserved bits always zero
   typedef struct packed {
      logic [1:0] rsv_hi;
      logic       dmme;
      logic       imme;
      logic       ire;
      logic       rm;
      logic [3:0] rsv_lo;
   } psr_t;

   // Software register numbers
   typedef enum logic [3:0] {
      MSR_PSR    = 4'd0,
      MSR_CPUID  = 4'd1,
      MSR_EPSR   = 4'd2,
      MSR_EPC    = 4'd3,
      MSR_ELSA   = 4'd4,
      MSR_COREID = 4'd5
   } msr_addr_t;

endpackage

`default_nettype wire

// File: rtl/ncpu_msr_defs.svh
// Width, PSR bit layout and CPUID field macros for the machine-state register unit and its testbench
`ifndef NCPU_MSR_DEFS_SVH
`define NCPU_MSR_DEFS_SVH

// Data and address width
`define NCPU_DW 32
`define NCPU_PSR_DW 10

// PSR bit positions, all other bits read as zero
`define NCPU_PSR_RM_BIT 4
`define NCPU_PSR_IRE_BIT 5
`define NCPU_PSR_IMME_BIT 6
`define NCPU_PSR_DMME_BIT 7

// Defined PSR bits only
`define NCPU_PSR_MASK ((`NCPU_PSR_DW'(1) << `NCPU_PSR_RM_BIT) | \
                       (`NCPU_PSR_DW'(1) << `NCPU_PSR_IRE_BIT) | \
                       (`NCPU_PSR_DW'(1) << `NCPU_PSR_IMME_BIT) | \
                       (`NCPU_PSR_DW'(1) << `NCPU_PSR_DMME_BIT))

// CPUID version and feature flags
`define NCPU_CPUID_VER 8'd1
`define NCPU_CPUID_REV 10'd0
`define NCPU_CPUID_FIMM 1'b1
`define NCPU_CPUID_FDMM 1'b1
`define NCPU_CPUID_FICA 1'b0
`define NCPU_CPUID_FDCA 1'b0
`define NCPU_CPUID_FDBG 1'b0
`define NCPU_CPUID_FFPU 1'b0
`define NCPU_CPUID_FIRQC 1'b1
`define NCPU_CPUID_FTSC 1'b1

// Packed CPUID word, VER in the low byte
`define NCPU_CPUID_VAL {{(`NCPU_DW-26){1'b0}}, `NCPU_CPUID_FTSC, `NCPU_CPUID_FIRQC, \
                        `NCPU_CPUID_FFPU, `NCPU_CPUID_FDBG, `NCPU_CPUID_FDCA, \
                        `NCPU_CPUID_FICA, `NCPU_CPUID_FDMM, `NCPU_CPUID_FIMM, \
                        `NCPU_CPUID_REV, `NCPU_CPUID_VER}

`endif
